/* include/clock_sync_config.svh */
`ifndef CLOCK_SYNC_CONFIG_SVH
`define CLOCK_SYNC_CONFIG_SVH

// local counter period in clocks.
`define CYCLE_PERIOD 16'd200

// nodes served by the master.
`define NODE_COUNT 4
`define NODE_WIDTH 2

// mailbox address bus width.
`define POINTER_WIDTH 8

// low-priority area sits below the high-priority node messages.
`define LOPRI_MSG_LENGTH 8
`define LOPRI_MAILBOXES 2

// bytes per high-priority node message.
`define HIPRI_MSG_LENGTH 16

// timestamps carried in each node message.
`define STAMPS_PER_NODE 4

// first byte of node 0's message.
`define HIPRI_BASE (`LOPRI_MSG_LENGTH * `LOPRI_MAILBOXES)

// entries in the timestamp table.
`define STAMP_COUNT (`NODE_COUNT * `STAMPS_PER_NODE)

`endif

/* sim.f */
+incdir+include
src/clock_sync_pkg.sv
src/local_counter.sv
src/timestamp_store.sv
src/offset_delay_calc.sv
src/clock_sync_top.sv
testbench/clock_sync_checker.sv
testbench/clock_sync_tb.sv

/* src/clock_sync_pkg.sv */
`include "clock_sync_config.svh"

package clock_sync_pkg;

	// timestamp or counter value.
	typedef logic [15:0] stamp_t;

	// one byte write into the mailbox area.
	typedef struct packed {
		logic [`POINTER_WIDTH-1:0] addr;
		logic [7:0]                data;
		logic                      we;
	} mbox_wr_t;

	typedef struct packed {
		stamp_t tx;
		stamp_t rx;
	} snapshot_t;

	// one bit per node.
	typedef logic [`NODE_COUNT-1:0] node_mask_t;

	typedef struct packed {
		node_mask_t rx_ok;
		node_mask_t sync_ok;
		node_mask_t slave_rdy;
		node_mask_t scope_trigger;
	} node_status_t;

	typedef struct packed {
		stamp_t offset;
		stamp_t delay;
	} node_result_t;

	typedef node_result_t [`NODE_COUNT-1:0] result_array_t;

	// node index in the upper bits, timestamp number in the lower two.
	typedef logic [`NODE_WIDTH+1:0] stamp_addr_t;

endpackage

/* src/clock_sync_top.sv */
`timescale 1ns/1ps

module clock_sync_top (
	input  logic                          clk_i,
	input  logic                          arst_n_i,
	input  clock_sync_pkg::mbox_wr_t      mbox_wr_i,
	input  logic [1:0]                    snapshot_req_i,
	output clock_sync_pkg::stamp_t        local_count_o,
	output clock_sync_pkg::result_array_t results_o,
	output clock_sync_pkg::node_status_t  status_o,
	output logic                          result_req_o,
	input  logic                          result_ack_i
);

	import clock_sync_pkg::*;

	logic cycle_start;
	logic cycle_take;
	snapshot_t snapshot;
	stamp_addr_t rd_addr;
	stamp_t rd_data;

	local_counter u_local_counter (
		.clk_i          (clk_i),
		.arst_n_i       (arst_n_i),
		.snapshot_req_i (snapshot_req_i),
		.count_o        (local_count_o),
		.cycle_start_o  (cycle_start),
		.snapshot_o     (snapshot)
	);

	timestamp_store u_timestamp_store (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.mbox_wr_i    (mbox_wr_i),
		.cycle_take_i (cycle_take),
		.rd_addr_i    (rd_addr),
		.rd_data_o    (rd_data),
		.status_o     (status_o)
	);

	offset_delay_calc u_offset_delay_calc (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.cycle_start_i (cycle_start),
		.snapshot_i    (snapshot),
		.cycle_take_o  (cycle_take),
		.rd_addr_o     (rd_addr),
		.rd_data_i     (rd_data),
		.results_o     (results_o),
		.result_req_o  (result_req_o),
		.result_ack_i  (result_ack_i)
	);

endmodule

/* src/local_counter.sv */
`timescale 1ns/1ps
`include "clock_sync_config.svh"

module local_counter (
	input  logic                      clk_i,
	input  logic                      arst_n_i,
	input  logic [1:0]                snapshot_req_i,
	output clock_sync_pkg::stamp_t    count_o,
	output logic                      cycle_start_o,
	output clock_sync_pkg::snapshot_t snapshot_o
);

	import clock_sync_pkg::*;

	stamp_t next_count;

	// last clock of the period.
	assign cycle_start_o = (count_o == `CYCLE_PERIOD - 16'd1);

	assign next_count = cycle_start_o ? '0 : count_o + 16'd1;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			count_o <= '0;
		end else begin
			count_o <= next_count;
		end
	end

	// snapshots hold the count seen at the requesting edge.
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			snapshot_o <= '0;
		end else begin
			if (snapshot_req_i[0]) begin
				snapshot_o.tx <= count_o;
			end
			if (snapshot_req_i[1]) begin
				snapshot_o.rx <= count_o;
			end
		end
	end

endmodule

/* src/offset_delay_calc.sv */
`timescale 1ns/1ps
`include "clock_sync_config.svh"

module offset_delay_calc (
	input  logic                          clk_i,
	input  logic                          arst_n_i,
	input  logic                          cycle_start_i,
	input  clock_sync_pkg::snapshot_t     snapshot_i,
	output logic                          cycle_take_o,
	output clock_sync_pkg::stamp_addr_t   rd_addr_o,
	input  clock_sync_pkg::stamp_t        rd_data_i,
	output clock_sync_pkg::result_array_t results_o,
	output logic                          result_req_o,
	input  logic                          result_ack_i
);

	import clock_sync_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_T0,
		S_T1,
		S_A,
		S_B,
		S_STORE,
		S_REQ,
		S_RELEASE
	} state_t;

	state_t state;
	logic [`NODE_WIDTH-1:0] node;
	logic [`NODE_WIDTH-1:0] node_prev;
	snapshot_t snap_r;
	stamp_t delay_acc;
	stamp_t offset_acc;
	stamp_t operand;
	logic first_node;

	// cycles arriving while busy are skipped.
	assign cycle_take_o = (state == S_IDLE) && cycle_start_i;

	assign first_node = (node == '0);
	assign node_prev = node - 1'b1;

	always_comb begin
		case (state)
			S_T0: rd_addr_o = {node, 2'd0};
			S_T1: rd_addr_o = {node, 2'd1};
			S_A: rd_addr_o = {node_prev, 2'd2};
			S_B: rd_addr_o = {node_prev, 2'd3};
			default: rd_addr_o = {node, 2'd0};
		endcase
	end

	// node 0 measures against the local snapshots, later nodes against their neighbour.
	always_comb begin
		if (!first_node) begin
			operand = rd_data_i;
		end else if (state == S_A) begin
			operand = snap_r.tx;
		end else begin
			operand = snap_r.rx;
		end
	end

	always_ff @(posedge clk_i) begin
		if (cycle_take_o) begin
			snap_r <= snapshot_i;
		end
		case (state)
			S_T0: begin
				delay_acc <= rd_data_i;
				offset_acc <= rd_data_i;
			end
			S_T1: begin
				delay_acc <= delay_acc - rd_data_i;
				offset_acc <= offset_acc + rd_data_i;
			end
			S_A: begin
				delay_acc <= delay_acc - operand;
				offset_acc <= offset_acc - operand;
			end
			S_B: begin
				delay_acc <= delay_acc + operand;
				offset_acc <= offset_acc - operand;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state <= S_IDLE;
			node <= '0;
			results_o <= '0;
			result_req_o <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					node <= '0;
					if (cycle_start_i) begin
						state <= S_T0;
					end
				end
				S_T0: state <= S_T1;
				S_T1: state <= S_A;
				S_A: state <= S_B;
				S_B: state <= S_STORE;
				S_STORE: begin
					results_o[node].offset <= offset_acc;
					results_o[node].delay <= delay_acc;
					node <= node + 1'b1;
					if (node == `NODE_WIDTH'(`NODE_COUNT - 1)) begin
						state <= S_REQ;
					end else begin
						state <= S_T0;
					end
				end
				S_REQ: begin
					if (result_ack_i) begin
						result_req_o <= 1'b0;
						state <= S_RELEASE;
					end else begin
						result_req_o <= 1'b1;
					end
				end
				S_RELEASE: begin
					if (!result_ack_i) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

/* src/timestamp_store.sv */
`timescale 1ns/1ps
`include "clock_sync_config.svh"

module timestamp_store (
	input  logic                         clk_i,
	input  logic                         arst_n_i,
	input  clock_sync_pkg::mbox_wr_t     mbox_wr_i,
	input  logic                         cycle_take_i,
	input  clock_sync_pkg::stamp_addr_t  rd_addr_i,
	output clock_sync_pkg::stamp_t       rd_data_o,
	output clock_sync_pkg::node_status_t status_o
);

	import clock_sync_pkg::*;

	logic [7:0] stamp_lo [`STAMP_COUNT];
	logic [7:0] stamp_hi [`STAMP_COUNT];
	logic [15:0] flags [`NODE_COUNT];

	node_mask_t rdy1;
	node_mask_t rdy2;
	node_mask_t chain_ok;
	node_mask_t lo_hit;
	node_mask_t hi_hit;
	node_mask_t flag_lo_hit;
	node_mask_t flag_hi_hit;
	stamp_addr_t wr_idx;
	node_status_t status_next;

	function automatic logic [`POINTER_WIDTH-1:0] byte_addr(input int node, input int offs);
		return `POINTER_WIDTH'(`HIPRI_BASE + node * `HIPRI_MSG_LENGTH + offs);
	endfunction

	// address decode of the high-priority node messages.
	always_comb begin
		lo_hit = '0;
		hi_hit = '0;
		flag_lo_hit = '0;
		flag_hi_hit = '0;
		wr_idx = '0;
		for (int n = 0; n < `NODE_COUNT; n++) begin
			if (mbox_wr_i.we && mbox_wr_i.addr == byte_addr(n, 2)) begin
				flag_lo_hit[n] = 1'b1;
			end
			if (mbox_wr_i.we && mbox_wr_i.addr == byte_addr(n, 3)) begin
				flag_hi_hit[n] = 1'b1;
			end
			for (int k = 0; k < `STAMPS_PER_NODE; k++) begin
				if (mbox_wr_i.we && mbox_wr_i.addr == byte_addr(n, 4 + 2 * k)) begin
					lo_hit[n] = 1'b1;
					wr_idx = stamp_addr_t'(n * `STAMPS_PER_NODE + k);
				end
				if (mbox_wr_i.we && mbox_wr_i.addr == byte_addr(n, 5 + 2 * k)) begin
					hi_hit[n] = 1'b1;
					wr_idx = stamp_addr_t'(n * `STAMPS_PER_NODE + k);
				end
			end
		end
	end

	// a node only counts once the node before it has a complete message.
	assign chain_ok = {rdy1[`NODE_COUNT-2:0] & rdy2[`NODE_COUNT-2:0], 1'b1};

	always_comb begin
		status_next = '0;
		for (int n = 0; n < `NODE_COUNT; n++) begin
			status_next.rx_ok[n] = rdy1[n] & rdy2[n];
			status_next.sync_ok[n] = status_next.rx_ok[n] & flags[n][0];
			status_next.slave_rdy[n] = status_next.sync_ok[n] & flags[n][1];
			status_next.scope_trigger[n] = status_next.rx_ok[n] & flags[n][2];
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rdy1 <= '0;
			rdy2 <= '0;
			status_o <= '0;
			for (int n = 0; n < `NODE_COUNT; n++) begin
				flags[n] <= '0;
			end
		end else if (cycle_take_i) begin
			status_o <= status_next;
			rdy1 <= '0;
			rdy2 <= '0;
			for (int n = 0; n < `NODE_COUNT; n++) begin
				flags[n] <= '0;
			end
		end else begin
			rdy1 <= rdy1 | (lo_hit & chain_ok);
			// high byte only counts after a low byte of the same node.
			rdy2 <= rdy2 | (hi_hit & chain_ok & rdy1);
			for (int n = 0; n < `NODE_COUNT; n++) begin
				if (flag_lo_hit[n]) begin
					flags[n][7:0] <= mbox_wr_i.data;
				end
				if (flag_hi_hit[n]) begin
					flags[n][15:8] <= mbox_wr_i.data;
				end
			end
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `STAMP_COUNT; i++) begin
				stamp_lo[i] <= '0;
				stamp_hi[i] <= '0;
			end
		end else begin
			if (|lo_hit) begin
				stamp_lo[wr_idx] <= mbox_wr_i.data;
			end
			if (|hi_hit) begin
				stamp_hi[wr_idx] <= mbox_wr_i.data;
			end
		end
	end

	assign rd_data_o = {stamp_hi[rd_addr_i], stamp_lo[rd_addr_i]};

endmodule

/* testbench/clock_sync_checker.sv */
`timescale 1ns/1ps

module clock_sync_checker (
	input logic                          clk_i,
	input logic                          arst_n_i,
	input logic                          result_req_i,
	input logic                          result_ack_i,
	input clock_sync_pkg::result_array_t results_i,
	input clock_sync_pkg::node_status_t  status_i
);

	// a new request only starts once the previous ack is gone.
	req_waits_ack_low: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!result_req_i && result_ack_i |=> !result_req_i)
		else $error("result request raised while ack still high");

	req_held_until_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		result_req_i && !result_ack_i |=> result_req_i)
		else $error("result request dropped before ack");

	// offered results and status stay frozen for the whole request.
	results_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		result_req_i && $past(result_req_i) |-> $stable(results_i) && $stable(status_i))
		else $error("results or status changed while request high");

endmodule

/* testbench/clock_sync_tb.sv */
`timescale 1ns/1ps
`include "clock_sync_config.svh"

module clock_sync_tb;

	import clock_sync_pkg::*;

	localparam int ROUNDS = 7;
	localparam int HOLD_CYCLES = 2 * `CYCLE_PERIOD + 10;
	localparam int REQ_LIMIT = 3 * `CYCLE_PERIOD;

	logic clk_i;
	logic arst_n_i;
	mbox_wr_t mbox_wr_i;
	logic [1:0] snapshot_req_i;
	stamp_t local_count_o;
	result_array_t results_o;
	node_status_t status_o;
	logic result_req_o;
	logic result_ack_i;

	// model of what the mailbox and snapshots hold.
	stamp_t stamp_m [`STAMP_COUNT];
	logic [15:0] flag_m [`NODE_COUNT];
	logic [`POINTER_WIDTH-1:0] wr_log [$];
	stamp_t snap_tx_m;
	stamp_t snap_rx_m;

	result_array_t exp_res_q [$];
	node_status_t exp_stat_q [$];
	int hold_q [$];
	int rounds_queued;
	int done_count;
	int checks;
	int errors;
	int unsigned seed_ret;

	clock_sync_top DUT (
		.clk_i          (clk_i),
		.arst_n_i       (arst_n_i),
		.mbox_wr_i      (mbox_wr_i),
		.snapshot_req_i (snapshot_req_i),
		.local_count_o  (local_count_o),
		.results_o      (results_o),
		.status_o       (status_o),
		.result_req_o   (result_req_o),
		.result_ack_i   (result_ack_i)
	);

	bind clock_sync_top clock_sync_checker u_checker (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.result_req_i (result_req_o),
		.result_ack_i (result_ack_i),
		.results_i    (results_o),
		.status_i     (status_o)
	);

	always #4 clk_i = ~clk_i;

	function automatic logic [`POINTER_WIDTH-1:0] node_addr(input int n, input int offs);
		return `POINTER_WIDTH'(`HIPRI_BASE + n * `HIPRI_MSG_LENGTH + offs);
	endfunction

	// replays the write order for the ready chain, then applies the offset/delay rule.
	function automatic void compute_expected(output result_array_t res, output node_status_t st);
		node_mask_t r1;
		node_mask_t r2;
		logic chain_ok;
		int rel;
		int n;
		int offs;
		stamp_t t0;
		stamp_t t1;
		stamp_t a;
		stamp_t b;
		r1 = '0;
		r2 = '0;
		foreach (wr_log[i]) begin
			rel = int'(wr_log[i]) - `HIPRI_BASE;
			n = rel / `HIPRI_MSG_LENGTH;
			offs = rel % `HIPRI_MSG_LENGTH;
			if (rel >= 0 && n < `NODE_COUNT && offs >= 4 && offs < 4 + 2 * `STAMPS_PER_NODE) begin
				chain_ok = 1'b1;
				if (n > 0) begin
					chain_ok = r1[n-1] & r2[n-1];
				end
				if (offs % 2 == 0) begin
					r1[n] = r1[n] | chain_ok;
				end else begin
					r2[n] = r2[n] | (chain_ok & r1[n]);
				end
			end
		end
		for (int k = 0; k < `NODE_COUNT; k++) begin
			st.rx_ok[k] = r1[k] & r2[k];
			st.sync_ok[k] = st.rx_ok[k] & flag_m[k][0];
			st.slave_rdy[k] = st.sync_ok[k] & flag_m[k][1];
			st.scope_trigger[k] = st.rx_ok[k] & flag_m[k][2];
			t0 = stamp_m[k * `STAMPS_PER_NODE];
			t1 = stamp_m[k * `STAMPS_PER_NODE + 1];
			a = snap_tx_m;
			b = snap_rx_m;
			if (k > 0) begin
				a = stamp_m[(k - 1) * `STAMPS_PER_NODE + 2];
				b = stamp_m[(k - 1) * `STAMPS_PER_NODE + 3];
			end
			res[k].delay = t0 - t1 - a + b;
			res[k].offset = t0 + t1 - a - b;
		end
	endfunction

	task automatic finish_run();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	endtask

	task automatic fail_timeout(input string what);
		errors++;
		$display("timeout at %0t ns while waiting for %s", $time, what);
		finish_run();
	endtask

	task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_outputs(input result_array_t res, input node_status_t st);
		for (int n = 0; n < `NODE_COUNT; n++) begin
			check_value($sformatf("node %0d offset", n), results_o[n].offset, res[n].offset);
			check_value($sformatf("node %0d delay", n), results_o[n].delay, res[n].delay);
		end
		check_value("rx_ok", 16'(status_o.rx_ok), 16'(st.rx_ok));
		check_value("sync_ok", 16'(status_o.sync_ok), 16'(st.sync_ok));
		check_value("slave_rdy", 16'(status_o.slave_rdy), 16'(st.slave_rdy));
		check_value("scope_trigger", 16'(status_o.scope_trigger), 16'(st.scope_trigger));
	endtask

	task automatic wait_req(input logic level, input int limit, input string what);
		int waited;
		waited = 0;
		while (result_req_o !== level) begin
			if (waited >= limit) begin
				fail_timeout(what);
			end
			@(posedge clk_i);
			#1;
			waited++;
		end
	endtask

	// writes stay well clear of the next cycle take.
	task automatic wait_window();
		int waited;
		waited = 0;
		while (local_count_o < 16'd30 || local_count_o >= 16'd100) begin
			if (waited >= 2 * `CYCLE_PERIOD) begin
				fail_timeout("the write window");
			end
			@(posedge clk_i);
			#1;
			waited++;
		end
	endtask

	task automatic wait_done(input int target);
		int waited;
		waited = 0;
		while (done_count < target) begin
			if (waited >= 6 * `CYCLE_PERIOD) begin
				fail_timeout("the result handshake");
			end
			@(posedge clk_i);
			#1;
			waited++;
		end
	endtask

	task automatic write_byte(input int n, input int offs, input logic [7:0] data);
		int idx;
		idx = n * `STAMPS_PER_NODE + (offs - 4) / 2;
		@(posedge clk_i);
		#1;
		mbox_wr_i.addr = node_addr(n, offs);
		mbox_wr_i.data = data;
		mbox_wr_i.we = 1'b1;
		wr_log.push_back(mbox_wr_i.addr);
		if (offs == 2) begin
			flag_m[n][7:0] = data;
		end else if (offs == 3) begin
			flag_m[n][15:8] = data;
		end else if (offs % 2 == 0) begin
			stamp_m[idx][7:0] = data;
		end else begin
			stamp_m[idx][15:8] = data;
		end
	endtask

	task automatic write_node(input int n);
		logic [15:0] word;
		word = 16'($urandom);
		write_byte(n, 2, word[7:0]);
		write_byte(n, 3, word[15:8]);
		for (int k = 0; k < `STAMPS_PER_NODE; k++) begin
			word = 16'($urandom);
			write_byte(n, 4 + 2 * k, word[7:0]);
			write_byte(n, 5 + 2 * k, word[15:8]);
		end
		@(posedge clk_i);
		#1;
		mbox_wr_i.we = 1'b0;
	endtask

	// the count seen here is the one stored at the next edge.
	task automatic pulse_snapshot(input int sel, output stamp_t seen);
		@(posedge clk_i);
		#1;
		snapshot_req_i = 2'b01 << sel;
		seen = local_count_o;
		@(posedge clk_i);
		#1;
		snapshot_req_i = '0;
	endtask

	task automatic run_round(input node_mask_t nodes, input bit snap, input int hold);
		result_array_t exp_res;
		node_status_t exp_stat;
		wait_window();
		for (int n = 0; n < `NODE_COUNT; n++) begin
			if (nodes[n]) begin
				write_node(n);
			end
		end
		if (snap) begin
			pulse_snapshot(0, snap_tx_m);
			repeat ($urandom_range(1, 8)) @(posedge clk_i);
			pulse_snapshot(1, snap_rx_m);
		end
		compute_expected(exp_res, exp_stat);
		exp_res_q.push_back(exp_res);
		exp_stat_q.push_back(exp_stat);
		hold_q.push_back(hold);
		// flags and ready bits are cleared by the take.
		for (int n = 0; n < `NODE_COUNT; n++) begin
			flag_m[n] = '0;
		end
		wr_log.delete();
		rounds_queued++;
		wait_done(rounds_queued);
	endtask

	initial begin : compare_proc
		result_array_t exp_res;
		node_status_t exp_stat;
		int hold;
		for (int r = 0; r < ROUNDS; r++) begin
			wait_req(1'b1, REQ_LIMIT, "a result request");
			// the count restarts at the take edge and so gives the request latency.
			check_value("local_count_o at result request", local_count_o,
				16'(5 * `NODE_COUNT + 1));
			if (exp_res_q.size() == 0) begin
				errors++;
				$display("result offered at %0t ns with no expected values queued", $time);
			end else begin
				exp_res = exp_res_q.pop_front();
				exp_stat = exp_stat_q.pop_front();
				hold = hold_q.pop_front();
				compare_outputs(exp_res, exp_stat);
				if (hold > 0) begin
					repeat (hold) @(posedge clk_i);
					#1;
					compare_outputs(exp_res, exp_stat);
				end
			end
			result_ack_i = 1'b1;
			wait_req(1'b0, 10, "the request release");
			// ack lingers so the request has to stay low until it is gone.
			repeat (2) @(posedge clk_i);
			#1;
			result_ack_i = 1'b0;
			done_count++;
		end
	end

	initial begin : stimulus_proc
		clk_i = 1'b0;
		arst_n_i = 1'b0;
		mbox_wr_i = '0;
		snapshot_req_i = '0;
		result_ack_i = 1'b0;
		seed_ret = $urandom(32'h4733_8599);
		for (int i = 0; i < `STAMP_COUNT; i++) begin
			stamp_m[i] = '0;
		end
		for (int n = 0; n < `NODE_COUNT; n++) begin
			flag_m[n] = '0;
		end
		snap_tx_m = '0;
		snap_rx_m = '0;
		repeat (3) @(posedge clk_i);
		#1;
		arst_n_i = 1'b1;
		check_value("result_req_o after reset", 16'(result_req_o), 16'd0);
		check_value("status_o after reset", status_o, 16'd0);
		run_round(4'b0000, 1'b0, 0);
		run_round(4'b1111, 1'b1, 0);
		run_round(4'b1111, 1'b1, 0);
		// node 1 stays silent and breaks the chain.
		run_round(4'b1101, 1'b1, 0);
		run_round(4'b1111, 1'b1, HOLD_CYCLES);
		run_round(4'b1111, 1'b1, 0);
		run_round(4'b0000, 1'b0, 0);
		finish_run();
	end

endmodule
